/* zsound_pkg.sv */
package zsound_pkg;

	////////////////////////////////////////////////////////////
	// bus widths
	////////////////////////////////////////////////////////////

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// one extra bit on top of the sample for the modulator carry
	localparam int ACC_W  = DATA_W + 1;

	typedef logic [ADDR_W-1:0] z80_addr_t;
	typedef logic [DATA_W-1:0] z80_data_t;

	// covox sample is a plain byte off the data bus
	typedef logic [DATA_W-1:0] covox_sample_t;

	typedef logic [ACC_W-1:0]  dac_acc_t;

	////////////////////////////////////////////////////////////
	// port map
	////////////////////////////////////////////////////////////

	// covox lives at #FB, only the low address byte is decoded
	localparam logic [7:0] PORT_COVOX = 8'hFB;

	// bits of the #FE byte that feed the sound path
	localparam int BEEP_BIT = 4;
	localparam int TAPE_BIT = 3;

	////////////////////////////////////////////////////////////
	// clock domain crossing
	////////////////////////////////////////////////////////////

	// flops per Z80 strobe before it is used in fclk logic
	localparam int SYNC_STAGES = 2;

endpackage

/* z80_port_write.sv */
module z80_port_write import zsound_pkg::*; (
	input  logic      fclk,
	input  logic      rst_n,

	// raw Z80 strobes, asynchronous to fclk
	input  logic      iorq_n,
	input  logic      wr_n,
	input  logic      m1_n,

	input  z80_addr_t a,
	input  z80_data_t d_in,

	output logic      iowr_s,
	output z80_addr_t wa,
	output z80_data_t wd
);

	////////////////////////////////////////////////////////////
	// strobe synchronizers
	////////////////////////////////////////////////////////////

	// chains hold the active-low levels as sampled
	logic [SYNC_STAGES-1:0] iorq_sync;
	logic [SYNC_STAGES-1:0] wr_sync;
	logic [SYNC_STAGES-1:0] m1_sync;

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			iorq_sync <= '1;
			wr_sync   <= '1;
			m1_sync   <= '1;
		end else begin
			iorq_sync <= {iorq_sync[SYNC_STAGES-2:0], iorq_n};
			wr_sync   <= {wr_sync[SYNC_STAGES-2:0], wr_n};
			m1_sync   <= {m1_sync[SYNC_STAGES-2:0], m1_n};
		end
	end

	////////////////////////////////////////////////////////////
	// write start detection
	////////////////////////////////////////////////////////////

	logic io_write;
	logic io_write_q;
	logic io_write_qq;
	logic io_start;

	// iorq with m1 is an int acknowledge, never a port write
	assign io_write = !iorq_sync[SYNC_STAGES-1] && !wr_sync[SYNC_STAGES-1] &&
		m1_sync[SYNC_STAGES-1];

	// rising edge of the registered condition
	assign io_start = io_write_q && !io_write_qq;

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			io_write_q  <= 1'b0;
			io_write_qq <= 1'b0;
			iowr_s      <= 1'b0;
		end else begin
			io_write_q  <= io_write;
			io_write_qq <= io_write_q;
			iowr_s      <= io_start;
		end
	end

	////////////////////////////////////////////////////////////
	// bus capture
	////////////////////////////////////////////////////////////

	// the bus has long been stable by now, so a plain capture is safe
	always_ff @(posedge fclk) begin
		if (io_start) begin
			wa <= a;
			wd <= d_in;
		end
	end

endmodule

/* beeper_port.sv */
module beeper_port import zsound_pkg::*; (
	input  logic      fclk,
	input  logic      rst_n,

	// synchronized write from z80_port_write
	input  logic      iowr_s,
	input  z80_addr_t wa,
	input  z80_data_t wd,

	// 0 picks the beeper, 1 picks tape out
	input  logic      beeper_mux,

	output logic      beep_level,
	output logic      beep_wr
);

	logic port_hit;
	logic beep_bit;
	logic tape_bit;

	////////////////////////////////////////////////////////////
	// #FE decode
	////////////////////////////////////////////////////////////

	// spectrum ula style, any even address is #FE
	assign port_hit = iowr_s && !wa[0];

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			beep_bit <= 1'b0;
			tape_bit <= 1'b0;
			beep_wr  <= 1'b0;
		end else begin
			beep_wr <= port_hit;
			if (port_hit) begin
				beep_bit <= wd[BEEP_BIT];
				tape_bit <= wd[TAPE_BIT];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// output select
	////////////////////////////////////////////////////////////

	// mux is a live level, switching it needs no new write
	always_comb begin
		if (beeper_mux) begin
			beep_level = tape_bit;
		end else begin
			beep_level = beep_bit;
		end
	end

endmodule

/* covox_dac.sv */
module covox_dac import zsound_pkg::*; (
	input  logic      fclk,
	input  logic      rst_n,

	// synchronized write from z80_port_write
	input  logic      iowr_s,
	input  z80_addr_t wa,
	input  z80_data_t wd,

	output logic      dac_bit,
	output logic      covox_wr
);

	logic          port_hit;
	covox_sample_t sample;
	dac_acc_t      acc;

	////////////////////////////////////////////////////////////
	// #FB decode and sample latch
	////////////////////////////////////////////////////////////

	// full low byte compare, high byte is don't care
	assign port_hit = iowr_s && (wa[7:0] == PORT_COVOX);

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			sample   <= '0;
			covox_wr <= 1'b0;
		end else begin
			covox_wr <= port_hit;
			if (port_hit) begin
				sample <= covox_sample_t'(wd);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// first order sigma-delta
	////////////////////////////////////////////////////////////

	// carry out of the low byte is the pulse density output.
	// with a constant sample v the carry fires v times per 256 clocks
	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= dac_acc_t'(acc[DATA_W-1:0]) + dac_acc_t'(sample);
		end
	end

	assign dac_bit = acc[ACC_W-1];

endmodule

/* sound_out.sv */
module sound_out (
	input  logic fclk,
	input  logic rst_n,

	// beeper / tape out source
	input  logic beep_level,
	input  logic beep_wr,

	// covox source
	input  logic dac_bit,
	input  logic covox_wr,

	output logic beep
);

	////////////////////////////////////////////////////////////
	// last writer tracking
	////////////////////////////////////////////////////////////

	// 0 is the beeper, 1 is the covox
	logic last_covox;
	logic next_covox;

	// write pulses never coincide, the ports are disjoint
	always_comb begin
		next_covox = last_covox;
		if (beep_wr) begin
			next_covox = 1'b0;
		end else if (covox_wr) begin
			next_covox = 1'b1;
		end
	end

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			last_covox <= 1'b0;
		end else begin
			last_covox <= next_covox;
		end
	end

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	// uses the updated selection so a fresh write shows up at once
	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			beep <= 1'b0;
		end else begin
			beep <= next_covox ? dac_bit : beep_level;
		end
	end

endmodule

/* zsound_top.sv */
module zsound_top import zsound_pkg::*; (
	input  logic      fclk,
	input  logic      rst_n,

	// Z80 bus
	input  logic      iorq_n,
	input  logic      wr_n,
	input  logic      m1_n,
	input  z80_addr_t a,
	input  z80_data_t d_in,

	// beeper or tape out onto the pin
	input  logic      beeper_mux,

	output logic      beep
);

	// synchronized port write
	logic      iowr_s;
	z80_addr_t wa;
	z80_data_t wd;

	logic beep_level;
	logic beep_wr;
	logic dac_bit;
	logic covox_wr;

	////////////////////////////////////////////////////////////
	// Z80 write into fclk domain
	////////////////////////////////////////////////////////////

	z80_port_write port_write (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.a      (a),
		.d_in   (d_in),
		.iowr_s (iowr_s),
		.wa     (wa),
		.wd     (wd)
	);

	////////////////////////////////////////////////////////////
	// sound sources
	////////////////////////////////////////////////////////////

	beeper_port beeper (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.iowr_s     (iowr_s),
		.wa         (wa),
		.wd         (wd),
		.beeper_mux (beeper_mux),
		.beep_level (beep_level),
		.beep_wr    (beep_wr)
	);

	covox_dac covox (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.iowr_s   (iowr_s),
		.wa       (wa),
		.wd       (wd),
		.dac_bit  (dac_bit),
		.covox_wr (covox_wr)
	);

	// last written source drives the pin
	sound_out sound (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.beep_level (beep_level),
		.beep_wr    (beep_wr),
		.dac_bit    (dac_bit),
		.covox_wr   (covox_wr),
		.beep       (beep)
	);

endmodule

/* zsound_checker.sv */
module zsound_checker import zsound_pkg::*; (
	input logic fclk,
	input logic rst_n,
	input logic iorq_n,
	input logic iowr_s,
	input logic beep
);

	timeunit 1ns;
	timeprecision 100ps;

	// iorq_n sample to a visible iowr_s, synchronizer plus edge detect
	localparam int WINDOW = SYNC_STAGES + 2;

	// consecutive cycles with iorq_n high, saturating
	logic [3:0] iorq_idle_run;

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			iorq_idle_run <= '0;
		end else if (!iorq_n) begin
			iorq_idle_run <= '0;
		end else if (iorq_idle_run != '1) begin
			iorq_idle_run <= iorq_idle_run + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// properties
	////////////////////////////////////////////////////////////

	beep_low_after_reset: assert property (
		@(posedge fclk) !rst_n |=> !beep
	) else $error("beep is not low in the cycle after reset");

	pulse_single_cycle: assert property (
		@(posedge fclk) disable iff (!rst_n) iowr_s |=> !iowr_s
	) else $error("iowr_s stayed high for two cycles");

	no_pulse_without_iorq: assert property (
		@(posedge fclk) disable iff (!rst_n) (iorq_idle_run >= WINDOW) |-> !iowr_s
	) else $error("iowr_s fired with iorq_n high across the synchronizer");

endmodule

bind zsound_top zsound_checker chk (
	.fclk   (fclk),
	.rst_n  (rst_n),
	.iorq_n (iorq_n),
	.iowr_s (iowr_s),
	.beep   (beep)
);

/* tb_zsound.sv */
module tb_zsound import zsound_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam real        CLK_HALF      = 2.0;
	localparam real        DRIVE_DELAY   = 0.5;
	localparam int         RESET_CYCLES  = 8;
	localparam int         RESET_TIMEOUT = 32;
	localparam int         WRITE_HOLD    = 6;
	localparam int         WRITE_IDLE    = 10;
	localparam int         DUTY_WINDOW   = 256;
	localparam logic [7:0] LFSR_SEED     = 8'd46;
	// x^8 + x^6 + x^5 + x^4 + 1
	localparam logic [7:0] LFSR_TAPS     = 8'hB8;

	logic      fclk;
	logic      rst_n;
	logic      iorq_n;
	logic      wr_n;
	logic      m1_n;
	z80_addr_t a;
	z80_data_t d_in;
	logic      beeper_mux;
	logic      beep;

	logic [7:0] lfsr = LFSR_SEED;
	int level_errors = 0;
	int count_errors = 0;
	int other_errors = 0;

	zsound_top uut (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.iorq_n     (iorq_n),
		.wr_n       (wr_n),
		.m1_n       (m1_n),
		.a          (a),
		.d_in       (d_in),
		.beeper_mux (beeper_mux),
		.beep       (beep)
	);

	always #CLK_HALF fclk = ~fclk;

	initial begin
		fclk       = 1'b0;
		rst_n      = 1'b0;
		iorq_n     = 1'b1;
		wr_n       = 1'b1;
		m1_n       = 1'b1;
		a          = '0;
		d_in       = '0;
		beeper_mux = 1'b0;
		repeat (RESET_CYCLES) @(posedge fclk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	// fibonacci shift, new bit enters at the bottom
	function automatic logic [7:0] lfsr_step(input logic [7:0] state);
		return {state[6:0], ^(state & LFSR_TAPS)};
	endfunction

	task automatic drive_step();
		@(posedge fclk);
		#DRIVE_DELAY;
	endtask

	// 0 to 7 extra cycles, one lfsr step per bit
	task automatic random_idle();
		int n;
		int i;
		n = 0;
		for (i = 0; i < 3; i++) begin
			lfsr = lfsr_step(lfsr);
			n = (n << 1) | lfsr[0];
		end
		repeat (n) drive_step();
	endtask

	task automatic wait_reset_release();
		int cyc;
		cyc = 0;
		while (rst_n !== 1'b1 && cyc < RESET_TIMEOUT) begin
			@(posedge fclk);
			cyc++;
		end
		#DRIVE_DELAY;
		if (rst_n !== 1'b1) begin
			other_errors++;
			$display("reset was not released within %0d cycles", RESET_TIMEOUT);
		end
	endtask

	// io write cycle, watching for the synchronized pulse inside the DUT
	task automatic z80_write(input string name, input z80_addr_t addr, input z80_data_t data,
		input logic mux);
		int   cyc;
		logic seen;
		seen       = 1'b0;
		beeper_mux = mux;
		a          = addr;
		d_in       = data;
		m1_n       = 1'b1;
		iorq_n     = 1'b0;
		wr_n       = 1'b0;
		for (cyc = 0; cyc < WRITE_HOLD + WRITE_IDLE; cyc++) begin
			@(negedge fclk);
			if (uut.iowr_s === 1'b1) begin
				seen = 1'b1;
			end
			drive_step();
			if (cyc == WRITE_HOLD - 1) begin
				iorq_n = 1'b1;
				wr_n   = 1'b1;
			end
		end
		if (!seen) begin
			other_errors++;
			$display("%s: write pulse never seen within %0d cycles", name,
				WRITE_HOLD + WRITE_IDLE);
		end
	endtask

	// wr is held low too, so only m1 keeps this from being a write
	task automatic int_ack(input z80_addr_t addr, input z80_data_t data);
		int cyc;
		a      = addr;
		d_in   = data;
		m1_n   = 1'b0;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		for (cyc = 0; cyc < WRITE_HOLD + WRITE_IDLE; cyc++) begin
			drive_step();
			if (cyc == WRITE_HOLD - 1) begin
				m1_n   = 1'b1;
				iorq_n = 1'b1;
				wr_n   = 1'b1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// result checks
	////////////////////////////////////////////////////////////

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			level_errors++;
			$display("ERROR %s beep level: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input dac_acc_t expected,
		input dac_acc_t actual);
		if (actual !== expected) begin
			count_errors++;
			$display("ERROR %s duty count: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// keeps the first wrong value seen in the window
	task automatic expect_level(input string name, input logic level);
		logic seen;
		int   cyc;
		seen = level;
		for (cyc = 0; cyc < DUTY_WINDOW; cyc++) begin
			@(negedge fclk);
			if (beep !== level && seen === level) begin
				seen = beep;
			end
		end
		drive_step();
		check_level(name, level, seen);
	endtask

	task automatic expect_count(input string name, input dac_acc_t count);
		dac_acc_t ones;
		int       cyc;
		ones = '0;
		for (cyc = 0; cyc < DUTY_WINDOW; cyc++) begin
			@(negedge fclk);
			ones = ones + dac_acc_t'(beep);
		end
		drive_step();
		check_count(name, count, ones);
	endtask

	task automatic malformed(input string name);
		other_errors++;
		$display("%s: trace line has missing or unreadable fields", name);
	endtask

	////////////////////////////////////////////////////////////
	// trace player
	////////////////////////////////////////////////////////////

	initial begin
		int               fd;
		int               nf;
		int               step;
		int               f_count;
		logic [15:0]      op;
		logic [8*128-1:0] rest;
		z80_addr_t        f_addr;
		z80_data_t        f_data;
		logic             f_bit;
		string            name;

		step = 0;
		wait_reset_release();
		fd = $fopen("zsound_trace.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("cannot open the trace file zsound_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				nf = $fscanf(fd, "%s", op);
				if (nf != 1) begin
					break;
				end
				if (op == "#") begin
					nf = $fgets(rest, fd);
				end else begin
					step++;
					name = $sformatf("step %0d", step);
					random_idle();
					case (op)
						"W": begin
							nf = $fscanf(fd, "%h %h %h", f_addr, f_data, f_bit);
							if (nf == 3) begin
								z80_write(name, f_addr, f_data, f_bit);
							end else begin
								malformed(name);
							end
						end
						"A": begin
							nf = $fscanf(fd, "%h %h", f_addr, f_data);
							if (nf == 2) begin
								int_ack(f_addr, f_data);
							end else begin
								malformed(name);
							end
						end
						"L": begin
							nf = $fscanf(fd, "%h", f_bit);
							if (nf == 1) begin
								expect_level(name, f_bit);
							end else begin
								malformed(name);
							end
						end
						"D": begin
							nf = $fscanf(fd, "%d", f_count);
							if (nf == 1) begin
								expect_count(name, dac_acc_t'(f_count));
							end else begin
								malformed(name);
							end
						end
						default: begin
							other_errors++;
							$display("%s: unknown opcode in the trace", name);
						end
					endcase
				end
			end
			$fclose(fd);
			if (step == 0) begin
				other_errors++;
				$display("the trace file holds no operations");
			end
		end

		$display("errors: %0d level, %0d count, %0d other", level_errors, count_errors,
			other_errors);
		if (level_errors + count_errors + other_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* zsound_trace.txt */
# ops: W addr data mux | A addr data  (addr and data in hex)
# checks: L beep level | D ones on beep over 256 cycles (decimal)
# state after reset
L 0
D 0
# beeper and tape out bits
W 00FE 10 0
L 1
W 00FE 08 0
L 0
W 00FE 08 1
L 1
W 00FE 00 0
L 0
# covox duty counts
W 00FB 00 0
D 0
W 00FB 01 0
D 1
W 00FB 80 0
D 128
W 00FB FF 0
D 255
W 00FB 55 0
D 85
# last writer wins
W 00FE 10 0
L 1
W 00FB 80 0
D 128
W 12FE 00 0
L 0
W 34FB 55 0
D 85
# other odd port and interrupt acknowledge
W 00FD 10 0
D 85
A 00FE 10
D 85
W 00FE 10 0
L 1
W 0077 00 0
L 1
A 00FB 00
L 1

/* sim.f */
zsound_pkg.sv
z80_port_write.sv
beeper_port.sv
covox_dac.sv
sound_out.sv
zsound_top.sv
zsound_checker.sv
tb_zsound.sv

/* Bender.yml */
package:
  name: zsound

sources:
  - zsound_pkg.sv
  - z80_port_write.sv
  - beeper_port.sv
  - covox_dac.sv
  - sound_out.sv
  - zsound_top.sv
  - target: test
    files:
      - zsound_checker.sv
      - tb_zsound.sv
